//--- prog.mem
// One 16-bit instruction per line in hex, starting at address 00
// Fields: op[15:12] imm[11:6] (rs in [8:6]) rt[5:3] rd[2:0]
6141 // 00 addi r1, r0, 5
6F42 // 01 addi r2, r0, -3
0053 // 02 add  r3, r1, r2
8CC3 // 03 sw   r3 -> F3 leds
1053 // 04 sub  r3, r1, r2
8CC3 // 05 sw   r3 -> leds
2053 // 06 and  r3, r1, r2
8CC3 // 07 sw   r3 -> leds
3053 // 08 or   r3, r1, r2
8CC3 // 09 sw   r3 -> leds
4053 // 0A xor  r3, r1, r2
8CC3 // 0B sw   r3 -> leds
508B // 0C slt  r3, r2, r1 (negative operand)
8CC3 // 0D sw   r3 -> leds
5053 // 0E slt  r3, r1, r2
8CC3 // 0F sw   r3 -> leds
8802 // 10 sw   r2 -> E0
7805 // 11 lw   r5 <- E0
8CC5 // 12 sw   r5 -> leds
906A // 13 beq  r5, r2, +1 (taken)
8CC1 // 14 sw   r1 -> leds (skipped)
904A // 15 beq  r1, r2, +1 (not taken)
6087 // 16 addi r7, r0, 2
6076 // 17 addi r6, r6, 1
9077 // 18 beq  r6, r7, +1
AF17 // 19 j    0xF17 -> 17
8CC6 // 1A sw   r6 -> leds
8C01 // 1B sw   r1 -> F0 scl
8C40 // 1C sw   r0 -> F1 sda low
8C00 // 1D sw   r0 -> F0 scl
8C80 // 1E sw   r0 -> F2 release sda
7C43 // 1F lw   r3 <- F1 sda pin
8CC3 // 20 sw   r3 -> leds
7C43 // 21 lw   r3 <- F1 sda pin
8CC3 // 22 sw   r3 -> leds
F000 // 23 halt

//--- sim.f
hw/cpu_pkg.sv
hw/step_gen.sv
hw/control.sv
hw/registers.sv
hw/alu.sv
hw/mem_io.sv
hw/display.sv
hw/cpu.sv
dv/cpu_tb.sv

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int step_timeout = 40;

	// Operands loaded into r1 and r2 by the first two addi instructions
	localparam logic [15:0] va = 16'd5;
	localparam logic [15:0] vb = 16'hFFFD;

	logic       MAX10_CLK1_50;
	logic       rst;
	logic       debug;
	logic       key_step;
	logic       scl;
	logic       sda_pull_low;
	logic [9:0] leds;
	seg_t [5:0] hex;
	wire        sda;

	cpu cpu_inst (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.debug         (debug),
		.key_step      (key_step),
		.scl           (scl),
		.sda           (sda),
		.leds          (leds),
		.hex           (hex)
	);

	// Bus pull-up plus a test driver that can hold the line low
	pullup (sda);
	assign sda = sda_pull_low ? 1'b0 : 1'bz;

	always #5 MAX10_CLK1_50 = ~MAX10_CLK1_50;

	// Standard active-low digit patterns with the point dark
	function automatic seg_t seg_pattern(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hC6;
			4'hD: return 8'hA1;
			4'hE: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	function automatic logic [47:0] digits_for(input logic [7:0] pc, input logic [15:0] ins);
		return {seg_pattern(pc[7:4]), seg_pattern(pc[3:0]), seg_pattern(ins[15:12]),
			seg_pattern(ins[11:8]), seg_pattern(ins[7:4]), seg_pattern(ins[3:0])};
	endfunction

	// LED value once the store after each ALU instruction has run
	function automatic logic [15:0] led_after(input int p);
		case (p)
			4:  return va + vb;
			6:  return va - vb;
			8:  return va & vb;
			10: return va | vb;
			12: return va ^ vb;
			14: return ($signed(vb) < $signed(va)) ? 16'd1 : 16'd0;
			default: return ($signed(va) < $signed(vb)) ? 16'd1 : 16'd0;
		endcase
	endfunction

	task automatic stop_with_error(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [47:0] expected,
		input logic [47:0] actual);
		string line;
		line = $sformatf("FAIL %s expected %0h actual %0h", name, expected, actual);
		assert (actual === expected) else stop_with_error(line);
	endtask

	task automatic check_leds(input logic [15:0] value);
		check_value("leds", {38'd0, value[9:0]}, {38'd0, leds});
	endtask

	task automatic check_shown_pc(input logic [7:0] exp_pc);
		check_value("hex[5:4]", {32'd0, seg_pattern(exp_pc[7:4]), seg_pattern(exp_pc[3:0])},
			{32'd0, hex[5], hex[4]});
	endtask

	// Key held for 4 clocks and released for 4 to cover the step latency
	task automatic press_key();
		key_step = 1'b0;
		repeat (4) @(negedge MAX10_CLK1_50);
		key_step = 1'b1;
		repeat (4) @(negedge MAX10_CLK1_50);
	endtask

	task automatic step_to(input logic [7:0] exp_pc);
		logic [15:0] start_pc;
		int          waited;
		start_pc = {hex[5], hex[4]};
		waited   = 0;
		press_key();
		while ({hex[5], hex[4]} === start_pc && waited < step_timeout) begin
			@(negedge MAX10_CLK1_50);
			waited++;
		end
		if ({hex[5], hex[4]} === start_pc)
			stop_with_error("Timed out waiting for the displayed program counter to change");
		check_shown_pc(exp_pc);
	endtask

	initial begin
		MAX10_CLK1_50 = 1'b0;
		rst           = 1'b0;
		debug         = 1'b1;
		key_step      = 1'b1;
		sda_pull_low  = 1'b0;
		repeat (2) @(negedge MAX10_CLK1_50);
		rst = 1'b1;
		@(negedge MAX10_CLK1_50);

		// Reset state with pc 00 and the first instruction shown
		check_value("hex", digits_for(8'h00, 16'h6141), hex);
		check_value("scl", 48'd0, {47'd0, scl});
		check_value("sda", 48'd1, {47'd0, sda});
		check_leds(16'd0);

		// Every ALU result goes out to the LEDs
		for (int p = 1; p <= 19; p++) begin
			step_to(8'(p));
			if (p >= 4 && p <= 16 && p % 2 == 0)
				check_leds(led_after(p));
		end
		// Memory round trip through address E0
		check_leds(vb);

		// Taken beq skips the store at 20
		step_to(8'd21);
		check_leds(vb);
		// Untaken beq and then a two-pass loop closed by the jump at 25
		step_to(8'd22);
		step_to(8'd23);
		step_to(8'd24);
		step_to(8'd25);
		step_to(8'd23);
		step_to(8'd24);
		step_to(8'd26);
		step_to(8'd27);
		check_leds(16'd2);

		// Bit-banged I2C lines
		step_to(8'd28);
		check_value("scl", 48'd1, {47'd0, scl});
		check_value("sda", 48'd1, {47'd0, sda});
		step_to(8'd29);
		check_value("sda", 48'd0, {47'd0, sda});
		step_to(8'd30);
		check_value("scl", 48'd0, {47'd0, scl});
		check_value("sda", 48'd0, {47'd0, sda});
		step_to(8'd31);
		check_value("sda", 48'd1, {47'd0, sda});

		sda_pull_low = 1'b1;
		step_to(8'd32);
		step_to(8'd33);
		check_leds(16'd0);
		sda_pull_low = 1'b0;
		step_to(8'd34);
		step_to(8'd35);
		check_leds(16'd1);

		// Further presses change nothing once halted
		repeat (2) begin
			press_key();
			check_shown_pc(8'd35);
			check_leds(16'd1);
		end

		// Run mode blanks the display
		debug = 1'b0;
		repeat (150) @(negedge MAX10_CLK1_50);
		check_value("hex", {6{8'hFF}}, hex);

		$display("Finished with no errors");
		$finish;
	end

endmodule

//--- hw/cpu.sv
`timescale 1ns/1ps

module cpu (
	input  logic                MAX10_CLK1_50,
	input  logic                rst,
	input  logic                debug,
	input  logic                key_step,
	output logic                scl,
	inout  wire                 sda,
	output logic [9:0]          leds,
	output cpu_pkg::seg_t [5:0] hex
);
	import cpu_pkg::*;

	logic                  step;
	mem_addr_t             pc;
	mem_addr_t             pc_next;
	instr_t                instr;
	ctrl_t                 ctrl;
	reg_idx_t              rs;
	reg_idx_t              rt;
	reg_idx_t              rd;
	logic [imm_width-1:0]  imm;
	logic [jimm_width-1:0] jimm;
	word_t                 imm_ext;
	word_t                 jimm_ext;
	word_t                 rs_val;
	word_t                 rt_val;
	word_t                 rd_val;
	word_t                 alu_a;
	word_t                 alu_out;
	word_t                 mem_rdata;
	word_t                 reg_in;
	logic                  beq_taken;

	// Field extraction, imm overlaps rs
	assign rs   = instr[3*num_regs_width-1 -: num_regs_width];
	assign rt   = instr[2*num_regs_width-1 -: num_regs_width];
	assign rd   = instr[num_regs_width-1:0];
	assign imm  = instr[instr_width-op_width-1 -: imm_width];
	assign jimm = instr[jimm_width-1:0];

	assign imm_ext  = {{(reg_width-imm_width){imm[imm_width-1]}}, imm};
	assign jimm_ext = {{(reg_width-jimm_width){jimm[jimm_width-1]}}, jimm};

	assign beq_taken = ctrl.is_beq && (rt_val == rd_val);

	always_comb begin
		if (ctrl.halted)
			pc_next = pc;
		else if (beq_taken)
			pc_next = pc + 1'b1 + imm_ext[mem_addr_width-1:0];
		else if (ctrl.jtype)
			pc_next = jimm_ext[mem_addr_width-1:0];
		else
			pc_next = pc + 1'b1;
	end

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst)
			pc <= '0;
		else if (step)
			pc <= pc_next;
	end

	assign alu_a  = ctrl.alu_use_imm ? imm_ext : rs_val;
	assign reg_in = ctrl.is_lw ? mem_rdata : alu_out;

	step_gen step_gen_inst (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.debug         (debug),
		.key_step      (key_step),
		.step          (step)
	);

	control control_inst (
		.instr (instr),
		.ctrl  (ctrl)
	);

	registers registers_inst (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.we            (ctrl.reg_write_en & step),
		.rs            (rs),
		.rt            (rt),
		.rd            (rd),
		.reg_in        (reg_in),
		.rs_val        (rs_val),
		.rt_val        (rt_val),
		.rd_val        (rd_val)
	);

	alu alu_inst (
		.op     (ctrl.alu_op),
		.a      (alu_a),
		.b      (rt_val),
		.result (alu_out)
	);

	// Data address is the low byte of the ALU result
	mem_io mem_io_inst (
		.MAX10_CLK1_50 (MAX10_CLK1_50),
		.rst           (rst),
		.we            (ctrl.is_sw & step),
		.addr          (alu_out[mem_addr_width-1:0]),
		.wdata         (rd_val),
		.iaddr         (pc),
		.instr         (instr),
		.rdata         (mem_rdata),
		.scl           (scl),
		.sda           (sda),
		.leds          (leds)
	);

	display display_inst (
		.enable (debug),
		.pc     (pc),
		.instr  (instr),
		.hex    (hex)
	);

endmodule

//--- hw/display.sv
`timescale 1ns/1ps

module display (
	input  logic                 enable,
	input  cpu_pkg::mem_addr_t   pc,
	input  cpu_pkg::instr_t      instr,
	output cpu_pkg::seg_t [5:0]  hex
);
	import cpu_pkg::*;

	function automatic seg_t hex_digit(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hC6;
			4'hD: return 8'hA1;
			4'hE: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	always_comb begin
		if (enable) begin
			// PC on the left pair, instruction on the right four
			hex[5] = hex_digit(pc[7:4]);
			hex[4] = hex_digit(pc[3:0]);
			hex[3] = hex_digit(instr[15:12]);
			hex[2] = hex_digit(instr[11:8]);
			hex[1] = hex_digit(instr[7:4]);
			hex[0] = hex_digit(instr[3:0]);
		end else begin
			hex = {6{seg_display_off}};
		end
	end

endmodule

//--- hw/mem_io.sv
`timescale 1ns/1ps

module mem_io (
	input  logic               MAX10_CLK1_50,
	input  logic               rst,
	input  logic               we,
	input  cpu_pkg::mem_addr_t addr,
	input  cpu_pkg::word_t     wdata,
	input  cpu_pkg::mem_addr_t iaddr,
	output cpu_pkg::instr_t    instr,
	output cpu_pkg::word_t     rdata,
	output logic               scl,
	inout  wire                sda,
	output logic [9:0]         leds
);
	import cpu_pkg::*;

	word_t mem [2**mem_addr_width];
	logic  is_io;
	logic  sda_oe;
	logic  sda_level;

	initial begin
		$readmemh(prog_file, mem);
	end

	assign is_io = addr inside {scl_addr, sda_addr, sda_clear_addr, led_addr};

	// Unified memory, instruction and data reads are both combinational
	assign instr = mem[iaddr];

	always_comb begin
		if (addr == sda_addr) begin
			rdata    = '0;
			rdata[0] = sda;
		end else begin
			rdata = mem[addr];
		end
	end

	always_ff @(posedge MAX10_CLK1_50) begin
		if (we && !is_io) begin
			mem[addr] <= wdata;
		end
	end

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			scl       <= 1'b0;
			sda_oe    <= 1'b0;
			sda_level <= 1'b0;
			leds      <= '0;
		end else if (we) begin
			case (addr)
				scl_addr: scl <= wdata[0];
				sda_addr: begin
					sda_oe    <= 1'b1;
					sda_level <= wdata[0];
				end
				sda_clear_addr: sda_oe <= 1'b0;
				led_addr:       leds   <= wdata[9:0];
				default: ;
			endcase
		end
	end

	// Released SDA floats and relies on the external pull-up
	assign sda = sda_oe ? sda_level : 1'bz;

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_e op,
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	output cpu_pkg::word_t   result
);
	import cpu_pkg::*;

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			// Signed compare, result is 0 or 1
			alu_slt: begin
				result = '0;
				result[0] = ($signed(a) < $signed(b));
			end
			default: result = '0;
		endcase
	end

endmodule

//--- hw/registers.sv
`timescale 1ns/1ps

module registers (
	input  logic              MAX10_CLK1_50,
	input  logic              rst,
	input  logic              we,
	input  cpu_pkg::reg_idx_t rs,
	input  cpu_pkg::reg_idx_t rt,
	input  cpu_pkg::reg_idx_t rd,
	input  cpu_pkg::word_t    reg_in,
	output cpu_pkg::word_t    rs_val,
	output cpu_pkg::word_t    rt_val,
	output cpu_pkg::word_t    rd_val
);
	import cpu_pkg::*;

	word_t regs [2**num_regs_width];

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < 2**num_regs_width; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[rd] <= reg_in;
		end
	end

	// Asynchronous read ports
	assign rs_val = regs[rs];
	assign rt_val = regs[rt];
	assign rd_val = regs[rd];

endmodule

//--- hw/control.sv
`timescale 1ns/1ps

module control (
	input  cpu_pkg::instr_t instr,
	output cpu_pkg::ctrl_t  ctrl
);
	import cpu_pkg::*;

	opcode_e opcode;

	assign opcode = opcode_e'(instr[instr_width-1 -: op_width]);

	always_comb begin
		// Unknown opcodes fall through as a no-op
		ctrl = '0;
		case (opcode)
			op_add: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_op       = alu_add;
			end
			op_sub: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_op       = alu_sub;
			end
			op_and: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_op       = alu_and;
			end
			op_or: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_op       = alu_or;
			end
			op_xor: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_op       = alu_xor;
			end
			op_slt: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_op       = alu_slt;
			end
			op_addi: begin
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_use_imm  = 1'b1;
			end
			op_lw: begin
				ctrl.is_lw        = 1'b1;
				ctrl.reg_write_en = 1'b1;
				ctrl.alu_use_imm  = 1'b1;
			end
			// Address is imm + rt, data comes from rd
			op_sw: begin
				ctrl.is_sw       = 1'b1;
				ctrl.alu_use_imm = 1'b1;
			end
			op_beq:  ctrl.is_beq = 1'b1;
			op_j:    ctrl.jtype  = 1'b1;
			op_halt: ctrl.halted = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

//--- hw/step_gen.sv
`timescale 1ns/1ps

module step_gen (
	input  logic MAX10_CLK1_50,
	input  logic rst,
	input  logic debug,
	input  logic key_step,
	output logic step
);
	import cpu_pkg::*;

	logic [$clog2(step_div)-1:0] div_cnt;
	logic                        run_tick;
	logic                        key_meta;
	logic                        key_sync;
	logic                        key_prev;
	logic                        key_fall;

	assign run_tick = (div_cnt == $bits(div_cnt)'(step_div - 1));

	// Key is active low, so a press is a falling edge
	assign key_fall = key_prev & ~key_sync;

	always_ff @(posedge MAX10_CLK1_50 or negedge rst) begin
		if (!rst) begin
			div_cnt  <= '0;
			key_meta <= 1'b1;
			key_sync <= 1'b1;
			key_prev <= 1'b1;
			step     <= 1'b0;
		end else begin
			div_cnt  <= run_tick ? '0 : div_cnt + 1'b1;
			key_meta <= key_step;
			key_sync <= key_meta;
			key_prev <= key_sync;
			step     <= debug ? key_fall : run_tick;
		end
	end

endmodule

//--- hw/cpu_pkg.sv
package cpu_pkg;

	// Field and bus widths
	localparam int instr_width    = 16;
	localparam int reg_width      = 16;
	localparam int op_width       = 4;
	localparam int num_regs_width = 3;
	localparam int imm_width      = 6;
	localparam int jimm_width     = 12;
	localparam int mem_addr_width = 8;

	typedef logic [reg_width-1:0]      word_t;
	typedef logic [instr_width-1:0]    instr_t;
	typedef logic [num_regs_width-1:0] reg_idx_t;
	typedef logic [mem_addr_width-1:0] mem_addr_t;

	// Active low, segments a..g in bits 0..6, point in bit 7
	typedef logic [7:0] seg_t;

	typedef enum logic [op_width-1:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_slt  = 4'd5,
		op_addi = 4'd6,
		op_lw   = 4'd7,
		op_sw   = 4'd8,
		op_beq  = 4'd9,
		op_j    = 4'd10,
		op_halt = 4'd15
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_e;

	typedef struct packed {
		logic    halted;
		logic    jtype;
		logic    is_beq;
		logic    is_lw;
		logic    is_sw;
		logic    alu_use_imm;
		logic    reg_write_en;
		alu_op_e alu_op;
	} ctrl_t;

	// Memory mapped I/O
	localparam mem_addr_t scl_addr       = 8'hF0;
	localparam mem_addr_t sda_addr       = 8'hF1;
	localparam mem_addr_t sda_clear_addr = 8'hF2;
	localparam mem_addr_t led_addr       = 8'hF3;

	localparam seg_t seg_display_off = 8'hFF;

	// Clocks per run-mode instruction
	localparam int step_div = 64;

	localparam prog_file = "prog.mem";

endpackage
